//--- Makefile
TOP = cpu_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f sources.f --top-module $(TOP) -Mdir obj_dir

# the simulator output is shown, and the pass line decides the exit status
run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed!"

clean:
	rm -rf obj_dir

//--- hdl/alu_unit.sv
`timescale 1ns/1ps

module alu_unit #(
    parameter int WIDTH = cpu_pkg::XLEN
)(
    exec_if.consumer         ex,
    output logic [WIDTH-1:0] alu_result,
    output logic             branch_taken,
    output logic [WIDTH-1:0] branch_target
);

import cpu_pkg::*;

localparam int SHW = $clog2(WIDTH);

logic [WIDTH-1:0] src_a;
logic [WIDTH-1:0] src_b;
logic [WIDTH-1:0] product;

assign src_a   = ex.rs1_val;
assign src_b   = ex.op.use_imm ? ex.imm : ex.rs2_val;
assign product = src_a * src_b; // only the low word is kept

always_comb begin
    case (ex.op.alu_op)
        ALU_ADD:    alu_result = src_a + src_b;
        ALU_SUB:    alu_result = src_a - src_b;
        ALU_AND:    alu_result = src_a & src_b;
        ALU_OR:     alu_result = src_a | src_b;
        ALU_XOR:    alu_result = src_a ^ src_b;
        ALU_SLT:    alu_result = WIDTH'($signed(src_a) < $signed(src_b));
        ALU_SLL:    alu_result = src_a << src_b[SHW-1:0];
        ALU_SRL:    alu_result = src_a >> src_b[SHW-1:0];
        ALU_MUL:    alu_result = product;
        ALU_PASS_B: alu_result = src_b;
        default:    alu_result = src_a + src_b;
    endcase
    if (ex.op.is_jump) begin
        alu_result = ex.pc + WIDTH'(4); // link address for jal
    end
end

// beq and bne compare the two registers, never the immediate
assign branch_taken  = ex.op.is_branch && ((ex.rs1_val == ex.rs2_val) ^ ex.op.branch_ne);
assign branch_target = ex.pc + ex.imm;

endmodule

//--- hdl/cpu.sv
`timescale 1ns/1ps

module cpu #(
    parameter int WIDTH      = cpu_pkg::XLEN,
    parameter int IMEM_DEPTH = cpu_pkg::IMEM_DEPTH
)(
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          trigger,
    input  logic                          prog_we,
    input  logic [$clog2(IMEM_DEPTH)-1:0] prog_addr,
    input  logic [WIDTH-1:0]              prog_data,
    output logic [WIDTH-1:0]              a0,
    output logic [WIDTH-1:0]              debug_pc_f,
    output logic [WIDTH-1:0]              debug_instr_f
);

logic [WIDTH-1:0] pc_f;
logic [WIDTH-1:0] instr_f;
logic [WIDTH-1:0] pc_d;
logic [WIDTH-1:0] instr_d;
logic             valid_d;

logic             stall;
logic             flush;
logic             redirect;
logic [WIDTH-1:0] redirect_pc;

logic             reg_write_w;
logic [4:0]       rd_w;
logic [WIDTH-1:0] result_w;

logic [WIDTH-1:0] alu_result;
logic             branch_taken;
logic [WIDTH-1:0] branch_target;
logic             div_busy;
logic             div_done;
logic [WIDTH-1:0] quotient;
logic [WIDTH-1:0] remainder;

assign debug_pc_f    = pc_f;
assign debug_instr_f = instr_f;

// ====================================================================
// fetch and decode
// ====================================================================
fetch #(.WIDTH(WIDTH), .IMEM_DEPTH(IMEM_DEPTH)) u_fetch (
    .clk         (clk),
    .rst         (rst),
    .prog_we     (prog_we),
    .prog_addr   (prog_addr),
    .prog_data   (prog_data),
    .stall       (stall),
    .flush       (flush),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .pc_f        (pc_f),
    .instr_f     (instr_f),
    .pc_d        (pc_d),
    .instr_d     (instr_d),
    .valid_d     (valid_d)
);

exec_if #(.WIDTH(WIDTH)) ex ();

decode #(.WIDTH(WIDTH)) u_decode (
    .clk         (clk),
    .rst         (rst),
    .pc_d        (pc_d),
    .instr_d     (instr_d),
    .valid_d     (valid_d),
    .stall       (stall),
    .flush       (flush),
    .reg_write_w (reg_write_w),
    .rd_w        (rd_w),
    .result_w    (result_w),
    .a0          (a0),
    .ex          (ex.producer)
);

// ====================================================================
// execute, alu and divider side by side
// ====================================================================
alu_unit #(.WIDTH(WIDTH)) u_alu (
    .ex            (ex.consumer),
    .alu_result    (alu_result),
    .branch_taken  (branch_taken),
    .branch_target (branch_target)
);

div_unit #(.WIDTH(WIDTH)) u_div (
    .clk       (clk),
    .rst       (rst),
    .ex        (ex.consumer),
    .div_busy  (div_busy),
    .div_done  (div_done),
    .quotient  (quotient),
    .remainder (remainder)
);

writeback #(.WIDTH(WIDTH)) u_writeback (
    .ex            (ex.consumer),
    .alu_result    (alu_result),
    .branch_taken  (branch_taken),
    .branch_target (branch_target),
    .div_busy      (div_busy),
    .div_done      (div_done),
    .quotient      (quotient),
    .remainder     (remainder),
    .reg_write_w   (reg_write_w),
    .rd_w          (rd_w),
    .result_w      (result_w),
    .redirect      (redirect),
    .redirect_pc   (redirect_pc),
    .stall         (stall),
    .flush         (flush)
);

endmodule

//--- hdl/cpu_pkg.sv
package cpu_pkg;

    localparam int XLEN       = 32;
    localparam int IMEM_DEPTH = 64;

    // major opcodes of the supported subset
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL     = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;
    localparam logic [2:0] F3_MUL     = 3'b000; // M extension, funct7 = F7_MULDIV
    localparam logic [2:0] F3_DIVU    = 3'b101;
    localparam logic [2:0] F3_REMU    = 3'b111;
    localparam logic [2:0] F3_BEQ     = 3'b000;
    localparam logic [2:0] F3_BNE     = 3'b001;

    localparam logic [6:0] F7_BASE   = 7'b0000000;
    localparam logic [6:0] F7_SUB    = 7'b0100000;
    localparam logic [6:0] F7_MULDIV = 7'b0000001;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLT, ALU_SLL, ALU_SRL, ALU_MUL, ALU_PASS_B
    } alu_op_t;

    // an all-zero value is a no-op: ADD with no register write
    typedef struct packed {
        alu_op_t    alu_op;
        logic       use_imm;
        logic       reg_write;
        logic       is_div;
        logic       div_rem;
        logic       is_branch;
        logic       branch_ne;
        logic       is_jump;
        logic [4:0] rd;
    } exec_op_t;

endpackage

//--- hdl/decode.sv
`timescale 1ns/1ps

module decode #(
    parameter int WIDTH = cpu_pkg::XLEN
)(
    input  logic             clk,
    input  logic             rst,
    input  logic [WIDTH-1:0] pc_d,
    input  logic [WIDTH-1:0] instr_d,
    input  logic             valid_d,
    input  logic             stall,
    input  logic             flush,
    input  logic             reg_write_w,
    input  logic [4:0]       rd_w,
    input  logic [WIDTH-1:0] result_w,
    output logic [WIDTH-1:0] a0,
    exec_if.producer         ex
);

import cpu_pkg::*;

logic [6:0]       opcode;
logic [2:0]       funct3;
logic [6:0]       funct7;
logic [4:0]       rs1;
logic [4:0]       rs2;
exec_op_t         op_d;
logic [WIDTH-1:0] imm_d;
logic [WIDTH-1:0] rs1_val_d;
logic [WIDTH-1:0] rs2_val_d;
logic [WIDTH-1:0] regs [32];

assign opcode = instr_d[6:0];
assign funct3 = instr_d[14:12];
assign funct7 = instr_d[31:25];
assign rs1    = instr_d[19:15];
assign rs2    = instr_d[24:20];

// ====================================================================
// instruction decoder
// ====================================================================
always_comb begin
    op_d    = '0;
    op_d.rd = instr_d[11:7];
    imm_d   = '0;
    case (opcode)
        OPC_OP: begin
            op_d.reg_write = 1'b1;
            if (funct7 == F7_MULDIV) begin
                case (funct3)
                    F3_MUL:  op_d.alu_op = ALU_MUL;
                    F3_DIVU: op_d.is_div = 1'b1;
                    F3_REMU: begin
                        op_d.is_div  = 1'b1;
                        op_d.div_rem = 1'b1;
                    end
                    default: op_d.reg_write = 1'b0; // high-word multiplies and signed divides
                endcase
            end else if (funct7 == F7_BASE) begin
                case (funct3)
                    F3_ADD_SUB: op_d.alu_op = ALU_ADD;
                    F3_SLL:     op_d.alu_op = ALU_SLL;
                    F3_SLT:     op_d.alu_op = ALU_SLT;
                    F3_XOR:     op_d.alu_op = ALU_XOR;
                    F3_SRL:     op_d.alu_op = ALU_SRL;
                    F3_OR:      op_d.alu_op = ALU_OR;
                    F3_AND:     op_d.alu_op = ALU_AND;
                    default:    op_d.reg_write = 1'b0; // sltu falls out as a no-op
                endcase
            end else if (funct7 == F7_SUB && funct3 == F3_ADD_SUB) begin
                op_d.alu_op = ALU_SUB;
            end else begin
                op_d.reg_write = 1'b0;
            end
        end
        OPC_OP_IMM: begin
            if (funct3 == F3_ADD_SUB) begin // only addi is supported
                op_d.use_imm   = 1'b1;
                op_d.reg_write = 1'b1;
                imm_d = {{(WIDTH-12){instr_d[31]}}, instr_d[31:20]};
            end
        end
        OPC_LUI: begin
            op_d.alu_op    = ALU_PASS_B;
            op_d.use_imm   = 1'b1;
            op_d.reg_write = 1'b1;
            imm_d = {{(WIDTH-32){instr_d[31]}}, instr_d[31:12], 12'b0};
        end
        OPC_BRANCH: begin
            op_d.is_branch = (funct3 == F3_BEQ) || (funct3 == F3_BNE);
            op_d.branch_ne = (funct3 == F3_BNE);
            imm_d = {{(WIDTH-12){instr_d[31]}}, instr_d[7], instr_d[30:25],
                     instr_d[11:8], 1'b0};
        end
        OPC_JAL: begin
            op_d.is_jump   = 1'b1;
            op_d.reg_write = 1'b1;
            imm_d = {{(WIDTH-20){instr_d[31]}}, instr_d[19:12], instr_d[20],
                     instr_d[30:21], 1'b0};
        end
        default: ;
    endcase
end

// ====================================================================
// register file, written from execute in the same cycle it is read here
// ====================================================================
always_ff @(posedge clk) begin
    if (rst) begin
        for (int i = 0; i < 32; i++) begin
            regs[i] <= '0;
        end
    end else if (reg_write_w && rd_w != 5'd0) begin
        regs[rd_w] <= result_w;
    end
end

assign rs1_val_d = (reg_write_w && rd_w != 5'd0 && rd_w == rs1) ? result_w : regs[rs1];
assign rs2_val_d = (reg_write_w && rd_w != 5'd0 && rd_w == rs2) ? result_w : regs[rs2];
assign a0        = regs[10];

// decode/execute register
always_ff @(posedge clk) begin
    if (rst || flush) begin
        ex.valid <= 1'b0;
    end else if (!stall) begin
        ex.valid <= valid_d;
    end
end

always_ff @(posedge clk) begin
    if (!stall) begin
        ex.op      <= op_d;
        ex.rs1_val <= rs1_val_d;
        ex.rs2_val <= rs2_val_d;
        ex.imm     <= imm_d;
        ex.pc      <= pc_d;
    end
end

endmodule

//--- hdl/div_unit.sv
`timescale 1ns/1ps

module div_unit #(
    parameter int WIDTH = cpu_pkg::XLEN
)(
    input  logic             clk,
    input  logic             rst,
    exec_if.consumer         ex,
    output logic             div_busy,
    output logic             div_done,
    output logic [WIDTH-1:0] quotient,
    output logic [WIDTH-1:0] remainder
);

localparam int CW = $clog2(WIDTH);

logic [CW-1:0]    count;
logic [WIDTH-1:0] divisor;
logic [WIDTH:0]   partial;
logic             fits;
logic             start;

// a divide still sitting in execute while done is high must not restart
assign start   = ex.valid && ex.op.is_div && !div_busy && !div_done;
assign partial = {remainder, quotient[WIDTH-1]};
assign fits    = partial >= {1'b0, divisor};

always_ff @(posedge clk) begin
    if (rst) begin
        div_busy <= 1'b0;
        div_done <= 1'b0;
        count    <= '0;
    end else begin
        div_done <= 1'b0;
        if (start) begin
            div_busy <= 1'b1;
            count    <= CW'(WIDTH-1);
        end else if (div_busy) begin
            if (count == '0) begin
                div_busy <= 1'b0;
                div_done <= 1'b1; // one cycle after the last iteration
            end else begin
                count <= count - 1'b1;
            end
        end
    end
end

// restoring shift-subtract, one quotient bit per cycle
// with a zero divisor every step fits, so the quotient fills with ones
// and the remainder collects the dividend unchanged
always_ff @(posedge clk) begin
    if (start) begin
        remainder <= '0;
        quotient  <= ex.rs1_val;
        divisor   <= ex.rs2_val;
    end else if (div_busy) begin
        remainder <= fits ? partial[WIDTH-1:0] - divisor : partial[WIDTH-1:0];
        quotient  <= {quotient[WIDTH-2:0], fits};
    end
end

endmodule

//--- hdl/exec_if.sv
`timescale 1ns/1ps

interface exec_if #(
    parameter int WIDTH = cpu_pkg::XLEN
)();

import cpu_pkg::*;

logic             valid;
exec_op_t         op;
logic [WIDTH-1:0] rs1_val;
logic [WIDTH-1:0] rs2_val;
logic [WIDTH-1:0] imm;
logic [WIDTH-1:0] pc;

// driven by the decode/execute register
modport producer (
    output valid, op, rs1_val, rs2_val, imm, pc
);

modport consumer (
    input valid, op, rs1_val, rs2_val, imm, pc
);

endinterface

//--- hdl/fetch.sv
`timescale 1ns/1ps

module fetch #(
    parameter int WIDTH      = cpu_pkg::XLEN,
    parameter int IMEM_DEPTH = cpu_pkg::IMEM_DEPTH
)(
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          prog_we,
    input  logic [$clog2(IMEM_DEPTH)-1:0] prog_addr,
    input  logic [WIDTH-1:0]              prog_data,
    input  logic                          stall,
    input  logic                          flush,
    input  logic                          redirect,
    input  logic [WIDTH-1:0]              redirect_pc,
    output logic [WIDTH-1:0]              pc_f,
    output logic [WIDTH-1:0]              instr_f,
    output logic [WIDTH-1:0]              pc_d,
    output logic [WIDTH-1:0]              instr_d,
    output logic                          valid_d
);

localparam int AW = $clog2(IMEM_DEPTH);

logic [WIDTH-1:0] imem [IMEM_DEPTH];

// the loader may only write while the core is held in reset
always_ff @(posedge clk) begin
    if (rst && prog_we) begin
        imem[prog_addr] <= prog_data;
    end
end

assign instr_f = imem[pc_f[AW+1:2]]; // pc bits above the array wrap around

always_ff @(posedge clk) begin
    if (rst) begin
        pc_f <= '0;
    end else if (redirect) begin
        pc_f <= redirect_pc;
    end else if (!stall) begin
        pc_f <= pc_f + WIDTH'(4);
    end
end

// fetch/decode register
always_ff @(posedge clk) begin
    if (rst || flush) begin
        valid_d <= 1'b0;
    end else if (!stall) begin
        valid_d <= 1'b1;
    end
end

always_ff @(posedge clk) begin
    if (!stall) begin
        pc_d    <= pc_f;
        instr_d <= instr_f;
    end
end

endmodule

//--- hdl/writeback.sv
`timescale 1ns/1ps

module writeback #(
    parameter int WIDTH = cpu_pkg::XLEN
)(
    exec_if.consumer         ex,
    input  logic [WIDTH-1:0] alu_result,
    input  logic             branch_taken,
    input  logic [WIDTH-1:0] branch_target,
    input  logic             div_busy,
    input  logic             div_done,
    input  logic [WIDTH-1:0] quotient,
    input  logic [WIDTH-1:0] remainder,
    output logic             reg_write_w,
    output logic [4:0]       rd_w,
    output logic [WIDTH-1:0] result_w,
    output logic             redirect,
    output logic [WIDTH-1:0] redirect_pc,
    output logic             stall,
    output logic             flush
);

logic div_op;

assign div_op = ex.valid && ex.op.is_div;

// the start cycle has neither busy nor done, the iterations have busy
assign stall = div_op && (div_busy || !div_done);

// a divide writes only in its done cycle, everything else at once
assign reg_write_w = ex.valid && ex.op.reg_write && (!ex.op.is_div || div_done);
assign rd_w        = ex.op.rd;

always_comb begin
    if (ex.op.is_div) begin
        result_w = ex.op.div_rem ? remainder : quotient;
    end else begin
        result_w = alu_result;
    end
end

assign redirect    = ex.valid && (branch_taken || ex.op.is_jump);
assign redirect_pc = branch_target;
assign flush       = redirect; // kills the instructions in fetch/decode and decode/execute

endmodule

//--- sources.f
hdl/cpu_pkg.sv
hdl/exec_if.sv
hdl/fetch.sv
hdl/decode.sv
hdl/alu_unit.sv
hdl/div_unit.sv
hdl/writeback.sv
hdl/cpu.sv
tests/cpu_asserts.sv
tests/cpu_tb.sv

//--- tests/cpu_asserts.sv
`timescale 1ns/1ps

module cpu_asserts #(
    parameter int WIDTH = cpu_pkg::XLEN
)(
    input logic             clk,
    input logic             rst,
    input logic             stall,
    input logic             flush,
    input logic             div_done,
    input logic [WIDTH-1:0] pc_f
);

int unsigned stall_run; // stall cycles seen so far in the current stall

always_ff @(posedge clk) begin
    if (rst || !stall) begin
        stall_run <= 0;
    end else begin
        stall_run <= stall_run + 1;
    end
end

// ====================================================================
// pipeline properties
// ====================================================================
stall_bounded: assert property (@(posedge clk) disable iff (rst) stall_run <= WIDTH + 2)
    else $error("stall held for more than %0d cycles", WIDTH + 2);

no_flush_in_stall: assert property (@(posedge clk) disable iff (rst) !(flush && stall))
    else $error("flush raised while the pipeline is stalled");

done_is_pulse: assert property (@(posedge clk) disable iff (rst) div_done |=> !div_done)
    else $error("div_done high for more than one cycle");

pc_aligned: assert property (@(posedge clk) disable iff (rst) pc_f[1:0] == 2'b00)
    else $error("pc_f is not word aligned");

endmodule

bind cpu cpu_asserts #(.WIDTH(WIDTH)) u_asserts (
    .clk      (clk),
    .rst      (rst),
    .stall    (stall),
    .flush    (flush),
    .div_done (div_done),
    .pc_f     (pc_f)
);

//--- tests/cpu_tb.sv
`timescale 1ns/1ps

module cpu_tb;

import cpu_pkg::*;

localparam int AW = $clog2(IMEM_DEPTH);

typedef enum int {
    I_ADD, I_SUB, I_AND, I_OR, I_XOR, I_SLT, I_SLL, I_SRL,
    I_ADDI, I_LUI, I_MUL, I_DIVU, I_REMU, I_BEQ, I_BNE, I_JAL
} instr_kind_t;

logic            clk;
logic            rst;
logic            trigger;
logic            prog_we;
logic [AW-1:0]   prog_addr;
logic [XLEN-1:0] prog_data;
logic [XLEN-1:0] a0;
logic [XLEN-1:0] debug_pc_f;
logic [XLEN-1:0] debug_instr_f;

// the current program, one entry per instruction word
instr_kind_t p_kind [IMEM_DEPTH];
logic [4:0]  p_rd   [IMEM_DEPTH];
logic [4:0]  p_rs1  [IMEM_DEPTH];
logic [4:0]  p_rs2  [IMEM_DEPTH];
logic [31:0] p_imm  [IMEM_DEPTH]; // byte offset for branches and jal
logic [31:0] p_word [IMEM_DEPTH];
int          halt_idx;

int test_errors;
int test_checks;
int total_errors;
int total_checks;

cpu #(.WIDTH(XLEN), .IMEM_DEPTH(IMEM_DEPTH)) uut (
    .clk           (clk),
    .rst           (rst),
    .trigger       (trigger),
    .prog_we       (prog_we),
    .prog_addr     (prog_addr),
    .prog_data     (prog_data),
    .a0            (a0),
    .debug_pc_f    (debug_pc_f),
    .debug_instr_f (debug_instr_f)
);

initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
end

// ====================================================================
// program generation and reference model
// ====================================================================
function automatic logic [31:0] encode_word(instr_kind_t k, logic [4:0] rd, logic [4:0] rs1,
                                            logic [4:0] rs2, logic [31:0] imm);
    logic [9:0] sel; // funct7 and funct3
    case (k)
        I_SUB:   sel = {F7_SUB, F3_ADD_SUB};
        I_AND:   sel = {F7_BASE, F3_AND};
        I_OR:    sel = {F7_BASE, F3_OR};
        I_XOR:   sel = {F7_BASE, F3_XOR};
        I_SLT:   sel = {F7_BASE, F3_SLT};
        I_SLL:   sel = {F7_BASE, F3_SLL};
        I_SRL:   sel = {F7_BASE, F3_SRL};
        I_MUL:   sel = {F7_MULDIV, F3_MUL};
        I_DIVU:  sel = {F7_MULDIV, F3_DIVU};
        I_REMU:  sel = {F7_MULDIV, F3_REMU};
        I_BNE:   sel = {F7_BASE, F3_BNE};
        default: sel = {F7_BASE, F3_ADD_SUB}; // add and beq
    endcase
    case (k)
        I_ADDI:       return {imm[11:0], rs1, F3_ADD_SUB, rd, OPC_OP_IMM};
        I_LUI:        return {imm[19:0], rd, OPC_LUI};
        I_BEQ, I_BNE: return {imm[12], imm[10:5], rs2, rs1, sel[2:0], imm[4:1], imm[11], OPC_BRANCH};
        I_JAL:        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
        default:      return {sel[9:3], rs2, rs1, sel[2:0], rd, OPC_OP};
    endcase
endfunction

// mode 0 alu and immediates, 1 multiply and divide, 2 control flow, 3 everything
function automatic instr_kind_t pick_kind(int mode);
    int r;
    r = $urandom % 20;
    case (mode)
        0:       return (r < 4) ? I_ADDI : (r < 6) ? I_LUI : instr_kind_t'(r % 8);
        1:       return (r < 9) ? instr_kind_t'(I_MUL + r % 3) : (r < 13) ? I_ADDI
                        : (r < 15) ? I_LUI : instr_kind_t'(r % 8);
        2:       return (r < 7) ? instr_kind_t'(I_BEQ + r % 3) : instr_kind_t'(r % 10);
        default: return instr_kind_t'(r % 16);
    endcase
endfunction

task automatic make_program(input int mode);
    int n_body;
    int last_rd;
    int j;
    n_body   = 28 + $urandom % 8;
    halt_idx = n_body + 14;
    last_rd  = 10;
    for (int i = 0; i < n_body; i++) begin
        p_kind[i] = pick_kind(mode);
        p_rd[i]   = ($urandom % 4 == 0) ? 5'd10 : 5'(1 + $urandom % 15);
        p_rs1[i]  = ($urandom % 2 == 0) ? 5'(last_rd) : 5'($urandom % 16); // back-to-back use
        p_rs2[i]  = ($urandom % 3 == 0) ? 5'(last_rd) : 5'($urandom % 16);
        if (p_kind[i] inside {I_DIVU, I_REMU} && $urandom % 4 == 0) begin
            p_rs2[i] = 5'd0; // divide by zero
        end
        if (p_kind[i] inside {I_BEQ, I_BNE} && $urandom % 3 == 0) begin
            p_rs2[i] = p_rs1[i];
        end
        if (p_kind[i] inside {I_BEQ, I_BNE, I_JAL}) begin
            p_imm[i] = 32'((2 + $urandom % 3) * 4); // skips 1 to 3 instructions
        end else begin
            p_imm[i] = $urandom;
        end
        last_rd = p_rd[i];
    end
    // fold every other register into x10 so that a0 sees all results
    j = n_body;
    for (int r = 1; r < 16; r++) begin
        if (r != 10) begin
            p_kind[j] = I_ADD;
            p_rd[j]   = 5'd10;
            p_rs1[j]  = 5'd10;
            p_rs2[j]  = 5'(r);
            p_imm[j]  = '0;
            j++;
        end
    end
    p_kind[halt_idx] = I_JAL; // jal x0 to itself
    p_rd[halt_idx]   = 5'd0;
    p_imm[halt_idx]  = '0;
    for (int a = 0; a < IMEM_DEPTH; a++) begin
        if (a <= halt_idx) begin
            p_word[a] = encode_word(p_kind[a], p_rd[a], p_rs1[a], p_rs2[a], p_imm[a]);
        end else begin
            p_word[a] = {12'(a), 5'd0, F3_ADD_SUB, 5'd0, OPC_OP_IMM}; // addi x0 with the address
        end
    end
endtask

function automatic logic [31:0] model_a0();
    logic [31:0] x [32];
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    int          i;
    int          next;
    int          steps;
    for (int r = 0; r < 32; r++) begin
        x[r] = '0;
    end
    i     = 0;
    steps = 0;
    while (i != halt_idx && steps < 200) begin
        a    = x[p_rs1[i]];
        b    = x[p_rs2[i]];
        res  = '0;
        next = i + 1;
        case (p_kind[i])
            I_ADD:   res = a + b;
            I_SUB:   res = a - b;
            I_AND:   res = a & b;
            I_OR:    res = a | b;
            I_XOR:   res = a ^ b;
            I_SLT:   res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            I_SLL:   res = a << b[4:0];
            I_SRL:   res = a >> b[4:0];
            I_ADDI:  res = a + {{20{p_imm[i][11]}}, p_imm[i][11:0]};
            I_LUI:   res = {p_imm[i][19:0], 12'h000};
            I_MUL:   res = a * b;
            I_DIVU:  res = (b == 0) ? 32'hffff_ffff : a / b;
            I_REMU:  res = (b == 0) ? a : a % b;
            I_JAL:   res = 32'(i * 4 + 4);
            default: ;
        endcase
        if ((p_kind[i] == I_BEQ && a == b) || (p_kind[i] == I_BNE && a != b)
                || p_kind[i] == I_JAL) begin
            next = i + int'(p_imm[i]) / 4;
        end
        if (!(p_kind[i] inside {I_BEQ, I_BNE}) && p_rd[i] != 5'd0) begin
            x[p_rd[i]] = res;
        end
        i = next;
        steps++;
    end
    return x[10];
endfunction

// ====================================================================
// driving, waiting and checking
// ====================================================================
task automatic next_cycle();
    @(posedge clk);
    #1;
endtask

// the loader runs under reset, then the core stays in reset 8 more cycles
task automatic load_and_reset();
    next_cycle();
    rst = 1'b1;
    for (int a = 0; a < IMEM_DEPTH; a++) begin
        next_cycle();
        prog_we   = 1'b1;
        prog_addr = AW'(a);
        prog_data = p_word[a];
    end
    next_cycle();
    prog_we = 1'b0;
    repeat (8) next_cycle();
    rst = 1'b0;
    @(negedge clk);
endtask

// the halt jal is refetched every third cycle once it loops
task automatic wait_for_halt(output bit reached);
    int  entries;
    bit  at_halt;
    entries = 0;
    at_halt = 1'b0;
    for (int cyc = 0; cyc < 20000 && entries < 4; cyc++) begin
        @(negedge clk);
        if (debug_pc_f == 32'(halt_idx * 4)) begin
            if (!at_halt) entries++;
            at_halt = 1'b1;
        end else begin
            at_halt = 1'b0;
        end
    end
    reached = (entries == 4);
endtask

task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    test_checks++;
    assert (got === exp) else begin
        $display("ERR t=%0t %s expected %h got %h", $time, name, exp, got);
        test_errors++;
    end
endtask

task automatic run_program(input int mode, input bit halt_checks);
    bit          reached;
    logic [31:0] expect_a0;
    make_program(mode);
    expect_a0 = model_a0();
    load_and_reset();
    wait_for_halt(reached);
    if (!reached) begin
        $display("timeout: the core did not reach its halt loop at %h within 20000 cycles",
                 halt_idx * 4);
        test_errors++;
    end else begin
        check_word("a0", a0, expect_a0);
        if (halt_checks) begin
            // the halt jal is back in fetch after its redirect and two bubble cycles
            repeat (3) @(negedge clk);
            check_word("debug_pc_f", debug_pc_f, 32'(halt_idx * 4));
            check_word("debug_instr_f", debug_instr_f, p_word[halt_idx]);
        end
    end
endtask

task automatic report_test(input int num, input string what);
    $display("test %0d %s: %0d checks, %0d errors", num, what, test_checks, test_errors);
    total_checks += test_checks;
    total_errors += test_errors;
    test_checks = 0;
    test_errors = 0;
endtask

initial begin
    rst          = 1'b1;
    trigger      = 1'b0;
    prog_we      = 1'b0;
    prog_addr    = '0;
    prog_data    = '0;
    test_errors  = 0;
    test_checks  = 0;
    total_errors = 0;
    total_checks = 0;
    void'($urandom(32'h11d1_1a89));

    make_program(0);
    load_and_reset();
    check_word("debug_pc_f", debug_pc_f, '0);
    check_word("a0", a0, '0);
    check_word("debug_instr_f", debug_instr_f, p_word[0]);
    report_test(1, "reset state");

    repeat (6) run_program(0, 1'b0);
    report_test(2, "alu and immediate programs");
    repeat (6) run_program(1, 1'b0);
    report_test(3, "multiply and divide programs");
    repeat (6) run_program(2, 1'b0);
    report_test(4, "branch and jump programs");
    repeat (3) run_program(3, 1'b1);
    report_test(5, "halt state");

    $display("checks %0d, errors %0d", total_checks, total_errors);
    if (total_errors == 0) begin
        $display("All tests passed!");
    end else begin
        $display("Test failures found");
    end
    $finish;
end

endmodule
